//--- design/bus_consts.svh
// Control and status bus constants
// Register map addresses, compatibility number and reset values

`ifndef BUS_CONSTS_SVH
`define BUS_CONSTS_SVH

// ------------------------------
// Settings bus addresses
// ------------------------------
`define SR_LEDS          8'd0
`define SR_SW_RST        8'd1
`define SR_CLOCK_CTRL    8'd2
`define SR_SFPP_CTRL0    8'd8
`define SR_SFPP_CTRL1    8'd9

// ------------------------------
// Readback bus addresses
// ------------------------------
`define RB_COUNTER       8'd0
`define RB_CLK_STATUS    8'd3
`define RB_COMPAT_NUM    8'd6
`define RB_SFPP_STATUS0  8'd8
`define RB_SFPP_STATUS1  8'd9

// ------------------------------
// Fixed values
// ------------------------------

// Compatibility number, major in the upper half of the word
`define COMPAT_MAJOR     16'h0014
`define COMPAT_MINOR     16'h0000

// Bit 6 on out of reset
`define CLOCK_CTRL_RESET 8'h40

`endif

//--- design/bus_pkg.sv
// Shared vector types for the control and status bus

package bus_pkg;

   // Settings bus
   typedef logic [7:0]  set_addr_t;
   typedef logic [31:0] set_data_t;

   // Readback bus
   typedef logic [7:0]  rb_addr_t;
   typedef logic [31:0] rb_data_t;

   // Per-cage PHY status
   typedef logic [15:0] phy_status_t;

   // Board outputs
   typedef logic [7:0]  led_t;

   // Soft resets
   // bit 0 PHY, bit 1 radio domain, bit 2 radio PLL, bit 3 ADC delay control
   typedef logic [3:0]  sw_rst_t;

   // Clock control and clock status share one width
   typedef logic [7:0]  clk_ctrl_t;

   // SFP+ rate-select drive-low enables, one bit per RS pin
   typedef logic [1:0]  sfpp_rs_t;

endpackage

//--- design/sfp_status_if.sv
// SFP+ cage status link
// Carries one cage's synchronized levels, sticky flags and clear-on-read request

`timescale 1ns/100ps

interface sfp_status_if;

   // Synchronized pin levels
   logic                  mod_abs;
   logic                  tx_fault;
   logic                  rx_los;

   // Sticky change flags
   logic                  mod_abs_chgd;
   logic                  tx_fault_chgd;
   logic                  rx_los_chgd;

   bus_pkg::phy_status_t  phy_status;

   // High in the cycle of a read strobe to this cage's status word
   logic                  clear;

   modport monitor (
      output mod_abs, tx_fault, rx_los,
      output mod_abs_chgd, tx_fault_chgd, rx_los_chgd,
      output phy_status,
      input  clear
   );

   modport reader (
      input  mod_abs, tx_fault, rx_los,
      input  mod_abs_chgd, tx_fault_chgd, rx_los_chgd,
      input  phy_status,
      output clear
   );

endinterface

//--- design/setting_regs.sv
// Settings register bank
// Decodes settings bus writes into the LED, soft reset, clock and rate-select registers

`timescale 1ns/100ps

`include "bus_consts.svh"

module setting_regs (
   input  logic                 clk,
   input  logic                 i_reset,

   // Settings bus
   input  logic                 i_set_stb,
   input  bus_pkg::set_addr_t   i_set_addr,
   input  bus_pkg::set_data_t   i_set_data,

   // Register outputs
   output bus_pkg::led_t        o_leds,
   output bus_pkg::sw_rst_t     o_sw_rst,
   output bus_pkg::clk_ctrl_t   o_clock_control,
   output bus_pkg::sfpp_rs_t    o_sfpp0_rs,
   output bus_pkg::sfpp_rs_t    o_sfpp1_rs
);

   // ------------------------------
   // Address decode
   // ------------------------------
   logic wr_leds;
   logic wr_sw_rst;
   logic wr_clock_ctrl;
   logic wr_sfpp0;
   logic wr_sfpp1;

   assign wr_leds       = i_set_stb && (i_set_addr == `SR_LEDS);
   assign wr_sw_rst     = i_set_stb && (i_set_addr == `SR_SW_RST);
   assign wr_clock_ctrl = i_set_stb && (i_set_addr == `SR_CLOCK_CTRL);
   assign wr_sfpp0      = i_set_stb && (i_set_addr == `SR_SFPP_CTRL0);
   assign wr_sfpp1      = i_set_stb && (i_set_addr == `SR_SFPP_CTRL1);

   // ------------------------------
   // Registers
   // ------------------------------

   // Each register keeps the low bits of the write data
   always_ff @(posedge clk) begin
      if (i_reset) begin
         o_leds   <= '0;
         o_sw_rst <= '0;
      end else begin
         if (wr_leds) begin
            o_leds <= i_set_data[7:0];
         end
         if (wr_sw_rst) begin
            o_sw_rst <= i_set_data[3:0];
         end
      end
   end

   // Clock control comes out of reset with bit 6 set
   always_ff @(posedge clk) begin
      if (i_reset) begin
         o_clock_control <= `CLOCK_CTRL_RESET;
      end else if (wr_clock_ctrl) begin
         o_clock_control <= i_set_data[7:0];
      end
   end

   // Rate-select enables, a set bit pulls that RS pin low on the board
   always_ff @(posedge clk) begin
      if (i_reset) begin
         o_sfpp0_rs <= '0;
         o_sfpp1_rs <= '0;
      end else begin
         if (wr_sfpp0) begin
            o_sfpp0_rs <= i_set_data[1:0];
         end
         if (wr_sfpp1) begin
            o_sfpp1_rs <= i_set_data[1:0];
         end
      end
   end

endmodule

//--- design/sfp_status_monitor.sv
// SFP+ cage status monitor
// Synchronizes cage pins and PHY status, latches pin changes until read

`timescale 1ns/100ps

module sfp_status_monitor (
   input  logic                   clk,
   input  logic                   i_reset,

   // Asynchronous cage pins
   input  logic                   i_mod_abs,
   input  logic                   i_tx_fault,
   input  logic                   i_rx_los,

   // Asynchronous PHY status
   input  bus_pkg::phy_status_t   i_phy_status,

   sfp_status_if.monitor          status
);

   // Pin vectors ordered module-absent, TX-fault, RX-loss from the top
   logic [2:0]            pin_meta;
   logic [2:0]            pin_sync;
   logic [2:0]            pin_prev;
   logic [2:0]            pin_chgd;

   bus_pkg::phy_status_t  phy_meta;
   bus_pkg::phy_status_t  phy_sync;

   // ------------------------------
   // Two-flop synchronizers
   // ------------------------------

   // Every bit is treated as asynchronous, PHY bits included
   always_ff @(posedge clk) begin
      if (i_reset) begin
         pin_meta <= '0;
         pin_sync <= '0;
         phy_meta <= '0;
         phy_sync <= '0;
      end else begin
         pin_meta <= {i_mod_abs, i_tx_fault, i_rx_los};
         pin_sync <= pin_meta;
         phy_meta <= i_phy_status;
         phy_sync <= phy_meta;
      end
   end

   // ------------------------------
   // Change detect
   // ------------------------------

   // Previous synchronized level
   always_ff @(posedge clk) begin
      if (i_reset) begin
         pin_prev <= '0;
      end else begin
         pin_prev <= pin_sync;
      end
   end

   // Sticky flags, a clear in the same cycle as a new change wins
   always_ff @(posedge clk) begin
      if (i_reset || status.clear) begin
         pin_chgd <= '0;
      end else begin
         pin_chgd <= pin_chgd | (pin_sync ^ pin_prev);
      end
   end

   // Outputs to the reader
   assign status.mod_abs       = pin_sync[2];
   assign status.tx_fault      = pin_sync[1];
   assign status.rx_los        = pin_sync[0];
   assign status.mod_abs_chgd  = pin_chgd[2];
   assign status.tx_fault_chgd = pin_chgd[1];
   assign status.rx_los_chgd   = pin_chgd[0];
   assign status.phy_status    = phy_sync;

endmodule

//--- design/readback_mux.sv
// Readback bus mux
// Free-running counter, readback word select and clear-on-read for the SFP+ status words

`timescale 1ns/100ps

`include "bus_consts.svh"

module readback_mux (
   input  logic                  clk,
   input  logic                  i_reset,

   // Readback bus
   input  logic                  i_rb_rd_stb,
   input  bus_pkg::rb_addr_t     i_rb_addr,
   output bus_pkg::rb_data_t     o_rb_data,

   // Raw clock status byte
   input  bus_pkg::clk_ctrl_t    i_clock_status,

   // Cage status
   sfp_status_if.reader          sfp0,
   sfp_status_if.reader          sfp1
);

   bus_pkg::rb_data_t  counter;
   bus_pkg::rb_data_t  sfp0_word;
   bus_pkg::rb_data_t  sfp1_word;

   // ------------------------------
   // Free-running counter
   // ------------------------------
   always_ff @(posedge clk) begin
      if (i_reset) begin
         counter <= '0;
      end else begin
         counter <= counter + 32'd1;
      end
   end

   // ------------------------------
   // Status words
   // ------------------------------

   // PHY bits on top, then flags, then live levels in the low bits
   assign sfp0_word = {
      sfp0.phy_status, 10'b0,
      sfp0.mod_abs_chgd, sfp0.tx_fault_chgd, sfp0.rx_los_chgd,
      sfp0.mod_abs, sfp0.tx_fault, sfp0.rx_los
   };

   assign sfp1_word = {
      sfp1.phy_status, 10'b0,
      sfp1.mod_abs_chgd, sfp1.tx_fault_chgd, sfp1.rx_los_chgd,
      sfp1.mod_abs, sfp1.tx_fault, sfp1.rx_los
   };

   // ------------------------------
   // Readback select
   // ------------------------------
   always_comb begin
      case (i_rb_addr)
         `RB_COUNTER:      o_rb_data = counter;
         `RB_CLK_STATUS:   o_rb_data = {24'b0, i_clock_status};
         `RB_COMPAT_NUM:   o_rb_data = {`COMPAT_MAJOR, `COMPAT_MINOR};
         `RB_SFPP_STATUS0: o_rb_data = sfp0_word;
         `RB_SFPP_STATUS1: o_rb_data = sfp1_word;
         default:          o_rb_data = '0;
      endcase
   end

   // ------------------------------
   // Clear-on-read
   // ------------------------------

   // Flags go back to zero at the edge that ends the read
   assign sfp0.clear = i_rb_rd_stb && (i_rb_addr == `RB_SFPP_STATUS0);
   assign sfp1.clear = i_rb_rd_stb && (i_rb_addr == `RB_SFPP_STATUS1);

endmodule

//--- design/sys_ctrl_top.sv
// System control and status top level
// Settings registers, SFP+ status monitors and readback mux

`timescale 1ns/100ps

module sys_ctrl_top (
   input  logic                   clk,
   input  logic                   i_reset,

   // Settings bus
   input  logic                   i_set_stb,
   input  bus_pkg::set_addr_t     i_set_addr,
   input  bus_pkg::set_data_t     i_set_data,

   // Readback bus
   input  logic                   i_rb_rd_stb,
   input  bus_pkg::rb_addr_t      i_rb_addr,
   output bus_pkg::rb_data_t      o_rb_data,

   // Clock status and control
   input  bus_pkg::clk_ctrl_t     i_clock_status,
   output bus_pkg::clk_ctrl_t     o_clock_control,

   // SFP+ cage 0
   input  logic                   i_sfpp0_mod_abs,
   input  logic                   i_sfpp0_tx_fault,
   input  logic                   i_sfpp0_rx_los,
   input  bus_pkg::phy_status_t   i_sfp0_phy_status,
   output bus_pkg::sfpp_rs_t      o_sfpp0_rs,

   // SFP+ cage 1
   input  logic                   i_sfpp1_mod_abs,
   input  logic                   i_sfpp1_tx_fault,
   input  logic                   i_sfpp1_rx_los,
   input  bus_pkg::phy_status_t   i_sfp1_phy_status,
   output bus_pkg::sfpp_rs_t      o_sfpp1_rs,

   // Board controls
   output bus_pkg::led_t          o_leds,
   output bus_pkg::sw_rst_t       o_sw_rst
);

   // One status link per cage
   sfp_status_if sfp0_if ();
   sfp_status_if sfp1_if ();

   // ------------------------------
   // Settings registers
   // ------------------------------
   setting_regs regs0 (
      .clk             (clk),
      .i_reset         (i_reset),
      .i_set_stb       (i_set_stb),
      .i_set_addr      (i_set_addr),
      .i_set_data      (i_set_data),
      .o_leds          (o_leds),
      .o_sw_rst        (o_sw_rst),
      .o_clock_control (o_clock_control),
      .o_sfpp0_rs      (o_sfpp0_rs),
      .o_sfpp1_rs      (o_sfpp1_rs)
   );

   // ------------------------------
   // SFP+ status monitors
   // ------------------------------
   sfp_status_monitor sfp0_mon (
      .clk          (clk),
      .i_reset      (i_reset),
      .i_mod_abs    (i_sfpp0_mod_abs),
      .i_tx_fault   (i_sfpp0_tx_fault),
      .i_rx_los     (i_sfpp0_rx_los),
      .i_phy_status (i_sfp0_phy_status),
      .status       (sfp0_if.monitor)
   );

   sfp_status_monitor sfp1_mon (
      .clk          (clk),
      .i_reset      (i_reset),
      .i_mod_abs    (i_sfpp1_mod_abs),
      .i_tx_fault   (i_sfpp1_tx_fault),
      .i_rx_los     (i_sfpp1_rx_los),
      .i_phy_status (i_sfp1_phy_status),
      .status       (sfp1_if.monitor)
   );

   // ------------------------------
   // Readback
   // ------------------------------
   readback_mux rb_mux0 (
      .clk            (clk),
      .i_reset        (i_reset),
      .i_rb_rd_stb    (i_rb_rd_stb),
      .i_rb_addr      (i_rb_addr),
      .o_rb_data      (o_rb_data),
      .i_clock_status (i_clock_status),
      .sfp0           (sfp0_if.reader),
      .sfp1           (sfp1_if.reader)
   );

endmodule

//--- dv/sys_ctrl_checker.sv
// Bus interface checker
// Assertions on register write timing, clock control reset value and readback decode

`timescale 1ns/100ps

`include "bus_consts.svh"

module sys_ctrl_checker (
   input logic                 clk,
   input logic                 i_reset,
   input logic                 i_set_stb,
   input bus_pkg::set_addr_t   i_set_addr,
   input bus_pkg::rb_addr_t    i_rb_addr,
   input bus_pkg::rb_data_t    i_rb_data,
   input bus_pkg::led_t        i_leds,
   input bus_pkg::sw_rst_t     i_sw_rst,
   input bus_pkg::clk_ctrl_t   i_clock_control
);

   // ------------------------------
   // Settings register timing
   // ------------------------------
   leds_change_on_write: assert property (@(posedge clk) disable iff (i_reset)
      !$stable(i_leds) |-> $past(i_reset) || $past(i_set_stb && (i_set_addr == `SR_LEDS)))
      else $error("LED register changed without a settings write to its address");

   sw_rst_change_on_write: assert property (@(posedge clk) disable iff (i_reset)
      !$stable(i_sw_rst) |-> $past(i_reset) || $past(i_set_stb && (i_set_addr == `SR_SW_RST)))
      else $error("Soft reset register changed without a settings write to its address");

   // First cycle out of reset
   clock_ctrl_reset_value: assert property (@(posedge clk)
      $fell(i_reset) |-> (i_clock_control == `CLOCK_CTRL_RESET))
      else $error("Clock control does not hold its reset value after reset");

   // ------------------------------
   // Readback decode
   // ------------------------------
   unmapped_read_zero: assert property (@(posedge clk) disable iff (i_reset)
      !(i_rb_addr inside {`RB_COUNTER, `RB_CLK_STATUS, `RB_COMPAT_NUM,
                          `RB_SFPP_STATUS0, `RB_SFPP_STATUS1}) |-> (i_rb_data == '0))
      else $error("Readback of an unmapped address returned nonzero data");

endmodule

bind sys_ctrl_top sys_ctrl_checker checker0 (
   .clk             (clk),
   .i_reset         (i_reset),
   .i_set_stb       (i_set_stb),
   .i_set_addr      (i_set_addr),
   .i_rb_addr       (i_rb_addr),
   .i_rb_data       (o_rb_data),
   .i_leds          (o_leds),
   .i_sw_rst        (o_sw_rst),
   .i_clock_control (o_clock_control)
);

//--- dv/sys_ctrl_tb.sv
// System control testbench
// Random settings writes and readback checked against a register and SFP+ flag model

`timescale 1ns/100ps

`include "bus_consts.svh"

module sys_ctrl_tb;

   // Cycle budgets per test
   // Watchdog limit is twice their sum
   localparam int RESET_CYCLES   = 10;
   localparam int WRITE_CYCLES   = 200;
   localparam int CONST_CYCLES   = 50;
   localparam int COUNTER_CYCLES = 10 * 34;
   localparam int STICKY_CYCLES  = 30 * 10;
   localparam int MAX_CYCLES     = 2 * (RESET_CYCLES + WRITE_CYCLES + CONST_CYCLES +
                                        COUNTER_CYCLES + STICKY_CYCLES);

   logic                  clk;
   logic                  i_reset;
   logic                  i_set_stb;
   bus_pkg::set_addr_t    i_set_addr;
   bus_pkg::set_data_t    i_set_data;
   logic                  i_rb_rd_stb;
   bus_pkg::rb_addr_t     i_rb_addr;
   bus_pkg::rb_data_t     o_rb_data;
   bus_pkg::clk_ctrl_t    i_clock_status;
   bus_pkg::clk_ctrl_t    o_clock_control;
   bus_pkg::led_t         o_leds;
   bus_pkg::sw_rst_t      o_sw_rst;
   bus_pkg::sfpp_rs_t     o_sfpp0_rs;
   bus_pkg::sfpp_rs_t     o_sfpp1_rs;

   // Cage pins as {mod_abs, tx_fault, rx_los}
   logic [2:0]            sfp_pins [0:1];
   bus_pkg::phy_status_t  sfp_phy [0:1];

   // Reference model
   bus_pkg::led_t         m_leds;
   bus_pkg::sw_rst_t      m_sw_rst;
   bus_pkg::clk_ctrl_t    m_clk_ctrl;
   bus_pkg::sfpp_rs_t     m_rs [0:1];
   logic [2:0]            m_flags [0:1];

   bus_pkg::set_addr_t    wr_map [0:4];
   bus_pkg::rb_data_t     d1;
   bus_pkg::rb_data_t     d2;
   logic [31:0]           r;
   integer                seed;
   int                    pass_count;
   int                    fail_count;
   int                    test_start;
   int                    cycle_count;
   int                    i;
   int                    c;
   int                    gap;

   sys_ctrl_top dut0 (
      .clk               (clk),
      .i_reset           (i_reset),
      .i_set_stb         (i_set_stb),
      .i_set_addr        (i_set_addr),
      .i_set_data        (i_set_data),
      .i_rb_rd_stb       (i_rb_rd_stb),
      .i_rb_addr         (i_rb_addr),
      .o_rb_data         (o_rb_data),
      .i_clock_status    (i_clock_status),
      .o_clock_control   (o_clock_control),
      .i_sfpp0_mod_abs   (sfp_pins[0][2]),
      .i_sfpp0_tx_fault  (sfp_pins[0][1]),
      .i_sfpp0_rx_los    (sfp_pins[0][0]),
      .i_sfp0_phy_status (sfp_phy[0]),
      .o_sfpp0_rs        (o_sfpp0_rs),
      .i_sfpp1_mod_abs   (sfp_pins[1][2]),
      .i_sfpp1_tx_fault  (sfp_pins[1][1]),
      .i_sfpp1_rx_los    (sfp_pins[1][0]),
      .i_sfp1_phy_status (sfp_phy[1]),
      .o_sfpp1_rs        (o_sfpp1_rs),
      .o_leds            (o_leds),
      .o_sw_rst          (o_sw_rst)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // Watchdog
   initial begin
      cycle_count = 0;
      while (cycle_count < MAX_CYCLES) begin
         @(posedge clk);
         cycle_count++;
      end
      $display("Timeout: the run did not finish within %0d clock cycles", MAX_CYCLES);
      $display("Test FAILED");
      $finish;
   end

   // ------------------------------
   // Helper tasks
   // ------------------------------

   // Inputs change 1 ns after the rising edge
   task automatic step();
      @(posedge clk);
      #1;
   endtask

   task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                              input string msg);
      if (actual !== expected) begin
         $display("Mismatch at %0t: %s, got %h expected %h", $time, msg, actual, expected);
         fail_count++;
      end else begin
         pass_count++;
      end
   endtask

   task automatic bus_write(input logic stb, input bus_pkg::set_addr_t addr,
                            input bus_pkg::set_data_t data);
      i_set_stb  = stb;
      i_set_addr = addr;
      i_set_data = data;
      step();
      i_set_stb  = 1'b0;
      if (stb) begin
         case (addr)
            `SR_LEDS:       m_leds     = data[7:0];
            `SR_SW_RST:     m_sw_rst   = data[3:0];
            `SR_CLOCK_CTRL: m_clk_ctrl = data[7:0];
            `SR_SFPP_CTRL0: m_rs[0]    = data[1:0];
            `SR_SFPP_CTRL1: m_rs[1]    = data[1:0];
            default:        ;
         endcase
      end
   endtask

   // Data taken at the falling edge before the strobe ends
   task automatic read_word(input bus_pkg::rb_addr_t addr, output bus_pkg::rb_data_t data);
      i_rb_rd_stb = 1'b1;
      i_rb_addr   = addr;
      @(negedge clk);
      data = o_rb_data;
      step();
      i_rb_rd_stb = 1'b0;
   endtask

   task automatic check_regs();
      check_value(o_leds, m_leds, "LED register");
      check_value(o_sw_rst, m_sw_rst, "soft reset register");
      check_value(o_clock_control, m_clk_ctrl, "clock control register");
      check_value(o_sfpp0_rs, m_rs[0], "cage 0 rate select");
      check_value(o_sfpp1_rs, m_rs[1], "cage 1 rate select");
   endtask

   // Reading a status word clears that cage's flags
   task automatic check_status(input int cage);
      bus_pkg::rb_data_t data;
      read_word(cage ? `RB_SFPP_STATUS1 : `RB_SFPP_STATUS0, data);
      check_value(data, {sfp_phy[cage], 10'b0, m_flags[cage], sfp_pins[cage]},
                  $sformatf("cage %0d status word", cage));
      m_flags[cage] = 3'b000;
   endtask

   task automatic report_test(input string name);
      $display("%s done, %0d errors", name, fail_count - test_start);
      test_start = fail_count;
   endtask

   // ------------------------------
   // Test sequence
   // ------------------------------
   initial begin
      seed = 32'hb5c0;
      pass_count = 0;
      fail_count = 0;
      test_start = 0;
      i_reset = 1'b1;
      i_set_stb = 1'b0;
      i_set_addr = '0;
      i_set_data = '0;
      i_rb_rd_stb = 1'b0;
      i_rb_addr = '0;
      i_clock_status = '0;
      sfp_pins[0] = 3'b000;
      sfp_pins[1] = 3'b000;
      sfp_phy[0] = '0;
      sfp_phy[1] = '0;
      m_leds = '0;
      m_sw_rst = '0;
      m_clk_ctrl = `CLOCK_CTRL_RESET;
      m_rs[0] = '0;
      m_rs[1] = '0;
      m_flags[0] = 3'b000;
      m_flags[1] = 3'b000;
      wr_map = '{`SR_LEDS, `SR_SW_RST, `SR_CLOCK_CTRL, `SR_SFPP_CTRL0, `SR_SFPP_CTRL1};

      repeat (3) @(posedge clk);
      #1;
      i_reset = 1'b0;

      // Counter must be read in the first cycle out of reset
      read_word(`RB_COUNTER, d1);
      check_value(d1, 32'd0, "counter after reset");
      check_regs();
      check_status(0);
      check_status(1);
      report_test("Test 1 reset values");

      // Mix of mapped and random addresses with the strobe sometimes low
      for (i = 0; i < 200; i++) begin
         r = $random(seed);
         bus_write(r[2:0] != 3'b000, r[3] ? wr_map[r[6:4] % 5] : r[15:8], $random(seed));
         check_regs();
      end
      report_test("Test 2 random writes");

      read_word(`RB_COMPAT_NUM, d1);
      check_value(d1, 32'h0014_0000, "compatibility number");
      for (i = 0; i < 20; i++) begin
         r = $random(seed);
         i_clock_status = r[7:0];
         read_word(`RB_CLK_STATUS, d1);
         check_value(d1, {24'b0, r[7:0]}, "clock status readback");
      end
      // Half of the addresses fall in the low page next to the map
      for (i = 0; i < 20; i++) begin
         r = $random(seed);
         if (r[8]) begin
            r[7:4] = 4'h0;
         end
         if (!(r[7:0] inside {`RB_COUNTER, `RB_CLK_STATUS, `RB_COMPAT_NUM,
                              `RB_SFPP_STATUS0, `RB_SFPP_STATUS1})) begin
            read_word(r[7:0], d1);
            check_value(d1, 32'd0, "unmapped readback");
         end
      end
      report_test("Test 3 constant readback");

      for (i = 0; i < 10; i++) begin
         read_word(`RB_COUNTER, d1);
         r = $random(seed);
         gap = r[4:0];
         repeat (gap) step();
         read_word(`RB_COUNTER, d2);
         // read_word itself spends one cycle
         check_value(d2 - d1, gap + 1, "counter difference");
      end
      report_test("Test 4 counter");

      for (i = 0; i < 30; i++) begin
         for (c = 0; c < 2; c++) begin
            r = $random(seed);
            sfp_pins[c] = sfp_pins[c] ^ r[2:0];
            m_flags[c] = m_flags[c] | r[2:0];
            if (r[3]) begin
               sfp_phy[c] = r[31:16];
            end
         end
         repeat (4 + r[5:4]) step();
         c = r[8];
         check_status(c);
         check_status(c);
         check_status(1 - c);
      end
      report_test("Tests 5 and 6 sticky flags and clear-on-read");

      $display("Checks passed: %0d, failed: %0d", pass_count, fail_count);
      if (fail_count == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

//--- project.f
+incdir+design
design/bus_pkg.sv
design/sfp_status_if.sv
design/setting_regs.sv
design/sfp_status_monitor.sv
design/readback_mux.sv
design/sys_ctrl_top.sv
dv/sys_ctrl_checker.sv
dv/sys_ctrl_tb.sv
